// File: FreeCachePkg.sv
package FreeCachePkg;

	// --------------------
	// field widths
	// --------------------

	// object or descriptor selector
	parameter int SEL_WIDTH = 24;
	// object length in bytes
	parameter int LEN_WIDTH = 32;
	// free and cached memory totals
	parameter int MEM_WIDTH = 40;

	// --------------------
	// command opcodes
	// --------------------

	typedef enum logic [3:0] {
		// table operations, run by the scan engine
		opWrite         = 4'h0,
		opClear         = 4'h1,
		opFindFreeObj   = 4'h2,
		opFindLength    = 4'h3,
		opFindFreeEntry = 4'h4,
		opFindUsedEntry = 4'h5,
		opCalcCached    = 4'h6,
		// free memory counter, handled in the result stage
		opMemNone       = 4'h7,
		opMemClear      = 4'h8,
		opMemAdd        = 4'h9,
		opMemSub        = 4'hA
	} freeOpT;

	// --------------------
	// scan engine states
	// --------------------

	typedef enum logic [1:0] {
		// waiting for start
		scIdle  = 2'd0,
		// issuing addresses, or clearing
		scRun   = 2'd1,
		// letting the last reads come back
		scDrain = 2'd2,
		// one cycle, done pulse
		scDone  = 2'd3
	} scanStateT;

endpackage

// File: FreeCacheRam.sv
`timescale 1ns/1ps

module FreeCacheRam #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                                                     CLK,
	input  logic                                                     we,
	input  logic [ADDR_WIDTH-1:0]                                    addr,
	input  logic [FreeCachePkg::SEL_WIDTH+FreeCachePkg::LEN_WIDTH-1:0] wdata,
	output logic [FreeCachePkg::SEL_WIDTH+FreeCachePkg::LEN_WIDTH-1:0] rdata
);
	import FreeCachePkg::*;

	// one entry per object or descriptor slot
	localparam int DEPTH = 1 << ADDR_WIDTH;
	// selector in the upper bits, length in the lower bits
	localparam int DATA_WIDTH = SEL_WIDTH + LEN_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// --------------------
	// single port access
	// --------------------

	// write first in the cycle
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// registered read, old data on a same-address write
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

endmodule

// File: FreeCmdDecode.sv
`timescale 1ns/1ps

module FreeCmdDecode #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                               CLK,
	input  logic                               RESETn,
	// command port from the requester
	input  logic                               cmdReq,
	output logic                               cmdAck,
	input  FreeCachePkg::freeOpT               cmdOp,
	input  logic [ADDR_WIDTH-1:0]              cmdIndex,
	input  logic [FreeCachePkg::SEL_WIDTH-1:0] cmdSel,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] cmdLength,
	// latched command towards engine and result stage
	output logic                               start,
	output FreeCachePkg::freeOpT               op,
	output logic [ADDR_WIDTH-1:0]              index,
	output logic [FreeCachePkg::SEL_WIDTH-1:0] sel,
	output logic [FreeCachePkg::LEN_WIDTH-1:0] length,
	// completion from either engine or result stage
	input  logic                               done
);

	// handshake phases
	typedef enum logic [1:0] {
		dcIdle = 2'd0,
		dcBusy = 2'd1,
		dcAck  = 2'd2
	} decStateT;

	decStateT state;
	logic accept;

	// new request only taken from idle
	assign accept = (state == dcIdle) && cmdReq;

	// --------------------
	// handshake FSM
	// --------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= dcIdle;
			start <= 1'b0;
			cmdAck <= 1'b0;
		end else begin
			// start is a single cycle pulse
			start <= accept;
			case (state)
				dcIdle: begin
					if (cmdReq) begin
						state <= dcBusy;
					end
				end
				dcBusy: begin
					// ack one cycle after done
					if (done) begin
						cmdAck <= 1'b1;
						state <= dcAck;
					end
				end
				dcAck: begin
					// hold ack until the request goes away
					if (!cmdReq) begin
						cmdAck <= 1'b0;
						state <= dcIdle;
					end
				end
				default: begin
					state <= dcIdle;
				end
			endcase
		end
	end

	// command fields, stable for the whole operation
	always_ff @(posedge CLK) begin
		if (accept) begin
			op <= cmdOp;
			index <= cmdIndex;
			sel <= cmdSel;
			length <= cmdLength;
		end
	end

endmodule

// File: FreeScanEngine.sv
`timescale 1ns/1ps

module FreeScanEngine #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                               CLK,
	input  logic                               RESETn,
	input  logic                               start,
	input  FreeCachePkg::freeOpT               op,
	input  logic [ADDR_WIDTH-1:0]              index,
	input  logic [FreeCachePkg::SEL_WIDTH-1:0] sel,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] length,
	output logic                               done,
	// first match of a scan
	output logic                               hit,
	output logic [ADDR_WIDTH-1:0]              hitIndex,
	output logic [FreeCachePkg::SEL_WIDTH-1:0] hitSel,
	output logic [FreeCachePkg::LEN_WIDTH-1:0] hitLength,
	// length stream for the cached total
	output logic                               sumValid,
	output logic [FreeCachePkg::LEN_WIDTH-1:0] sumLength
);
	import FreeCachePkg::*;

	localparam int ENTRY_WIDTH = SEL_WIDTH + LEN_WIDTH;
	// upper half holds objects, lower half descriptors
	localparam logic [ADDR_WIDTH-1:0] OBJ_BASE = {1'b1, {(ADDR_WIDTH-1){1'b0}}};
	localparam logic [ADDR_WIDTH-1:0] DESC_LAST = {1'b0, {(ADDR_WIDTH-1){1'b1}}};
	localparam logic [ADDR_WIDTH-1:0] TABLE_LAST = '1;

	scanStateT state;
	logic [ADDR_WIDTH-1:0] addrReg;
	logic [ADDR_WIDTH-1:0] lastAddr;
	logic issue;
	logic pipeValid;
	logic [ADDR_WIDTH-1:0] pipeAddr;
	logic ramWe;
	logic [ADDR_WIDTH-1:0] ramAddr;
	logic [ENTRY_WIDTH-1:0] ramWdata;
	logic [ENTRY_WIDTH-1:0] ramRdata;
	logic [SEL_WIDTH-1:0] rdSel;
	logic [LEN_WIDTH-1:0] rdLength;
	logic cond;
	logic match;

	// --------------------
	// table access
	// --------------------

	// idle side serves opWrite, run side walks addrReg
	assign ramWe = ((state == scIdle) && start && (op == opWrite))
		|| ((state == scRun) && (op == opClear));
	assign ramAddr = (state == scIdle) ? index : addrReg;
	assign ramWdata = (state == scIdle) ? {sel, length} : '0;

	FreeCacheRam #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) ram0 (
		.CLK(CLK),
		.we(ramWe),
		.addr(ramAddr),
		.wdata(ramWdata),
		.rdata(ramRdata)
	);

	assign rdSel = ramRdata[ENTRY_WIDTH-1:LEN_WIDTH];
	assign rdLength = ramRdata[LEN_WIDTH-1:0];

	// descriptor scans stop at the middle of the table
	always_comb begin
		case (op)
			opFindFreeEntry,
			opFindUsedEntry: lastAddr = DESC_LAST;
			default: lastAddr = TABLE_LAST;
		endcase
	end

	// --------------------
	// match detection
	// --------------------
	always_comb begin
		case (op)
			opFindFreeObj,
			opFindFreeEntry: cond = (rdSel == '0);
			opFindUsedEntry: cond = (rdSel != '0);
			opFindLength: cond = (rdLength >= length);
			default: cond = 1'b0;
		endcase
	end

	// only the first returned match counts
	assign match = pipeValid && !hit && cond;

	// reads only for scans, the clear pass just writes
	assign issue = (state == scRun) && (op != opClear);

	assign done = (state == scDone);
	assign sumValid = pipeValid && (op == opCalcCached);
	assign sumLength = rdLength;

	// --------------------
	// scan FSM
	// --------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= scIdle;
			addrReg <= '0;
			hit <= 1'b0;
			pipeValid <= 1'b0;
		end else begin
			pipeValid <= issue;
			if (start) begin
				hit <= 1'b0;
			end else if (match) begin
				hit <= 1'b1;
			end
			case (state)
				scIdle: begin
					if (start) begin
						case (op)
							// write goes out this cycle
							opWrite: state <= scDone;
							opClear,
							opFindFreeEntry,
							opFindUsedEntry: begin
								addrReg <= '0;
								state <= scRun;
							end
							opFindFreeObj,
							opFindLength,
							opCalcCached: begin
								addrReg <= OBJ_BASE;
								state <= scRun;
							end
							// memory opcodes are not ours
							default: state <= scIdle;
						endcase
					end
				end
				scRun: begin
					addrReg <= addrReg + 1'b1;
					if (op == opClear) begin
						if (addrReg == lastAddr) begin
							state <= scDone;
						end
					end else if (match || (addrReg == lastAddr)) begin
						state <= scDrain;
					end
				end
				scDrain: begin
					// wait for the read still in flight
					if (!pipeValid) begin
						state <= scDone;
					end
				end
				default: begin
					state <= scIdle;
				end
			endcase
		end
	end

	// address tag follows its read by one cycle
	always_ff @(posedge CLK) begin
		pipeAddr <= addrReg;
		if (match) begin
			hitIndex <= pipeAddr;
			hitSel <= rdSel;
			hitLength <= rdLength;
		end
	end

endmodule

// File: FreeResult.sv
`timescale 1ns/1ps

module FreeResult #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                               CLK,
	input  logic                               RESETn,
	input  logic                               start,
	input  FreeCachePkg::freeOpT               op,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] length,
	// from the scan engine
	input  logic                               engineDone,
	input  logic                               hit,
	input  logic [ADDR_WIDTH-1:0]              hitIndex,
	input  logic [FreeCachePkg::SEL_WIDTH-1:0] hitSel,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] hitLength,
	input  logic                               sumValid,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] sumLength,
	// completion of memory opcodes
	output logic                               done,
	// visible results
	output logic                               found,
	output logic [ADDR_WIDTH-1:0]              foundIndex,
	output logic [FreeCachePkg::SEL_WIDTH-1:0] foundSel,
	output logic [FreeCachePkg::LEN_WIDTH-1:0] foundLength,
	output logic [FreeCachePkg::MEM_WIDTH-1:0] freeMem,
	output logic [FreeCachePkg::MEM_WIDTH-1:0] cachedMem
);
	import FreeCachePkg::*;

	localparam int PAD_WIDTH = MEM_WIDTH - LEN_WIDTH;
	localparam logic [MEM_WIDTH-1:0] MEM_ONE = 1;

	logic memOp;
	logic [MEM_WIDTH-1:0] lengthExt;
	logic [MEM_WIDTH-1:0] sumExt;

	// counter opcodes never reach the engine
	assign memOp = (op == opMemNone) || (op == opMemClear)
		|| (op == opMemAdd) || (op == opMemSub);
	assign lengthExt = {{PAD_WIDTH{1'b0}}, length};
	assign sumExt = {{PAD_WIDTH{1'b0}}, sumLength};

	// --------------------
	// accumulators
	// --------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			done <= 1'b0;
			found <= 1'b0;
			freeMem <= '0;
			cachedMem <= '0;
		end else begin
			done <= start && memOp;
			if (engineDone) begin
				found <= hit;
			end
			// free memory counter, sub also drops one more
			if (start) begin
				case (op)
					opMemClear: freeMem <= '0;
					opMemAdd: freeMem <= freeMem + lengthExt;
					opMemSub: freeMem <= freeMem - lengthExt - MEM_ONE;
					default: freeMem <= freeMem;
				endcase
			end
			// cached total restarts with each calc pass
			if (start && (op == opCalcCached)) begin
				cachedMem <= '0;
			end else if (sumValid) begin
				cachedMem <= cachedMem + sumExt;
			end
		end
	end

	// found entry fields, same cycle as engine done
	always_ff @(posedge CLK) begin
		if (engineDone) begin
			foundIndex <= hitIndex;
			foundSel <= hitSel;
			foundLength <= hitLength;
		end
	end

endmodule

// File: FreeCache.sv
`timescale 1ns/1ps

module FreeCache #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                               CLK,
	input  logic                               RESETn,
	// four-phase command port
	input  logic                               cmdReq,
	output logic                               cmdAck,
	input  FreeCachePkg::freeOpT               cmdOp,
	input  logic [ADDR_WIDTH-1:0]              cmdIndex,
	input  logic [FreeCachePkg::SEL_WIDTH-1:0] cmdSel,
	input  logic [FreeCachePkg::LEN_WIDTH-1:0] cmdLength,
	// results, valid while cmdAck is high
	output logic                               found,
	output logic [ADDR_WIDTH-1:0]              foundIndex,
	output logic [FreeCachePkg::SEL_WIDTH-1:0] foundSel,
	output logic [FreeCachePkg::LEN_WIDTH-1:0] foundLength,
	output logic [FreeCachePkg::MEM_WIDTH-1:0] freeMem,
	output logic [FreeCachePkg::MEM_WIDTH-1:0] cachedMem
);
	import FreeCachePkg::*;

	logic start;
	freeOpT op;
	logic [ADDR_WIDTH-1:0] index;
	logic [SEL_WIDTH-1:0] sel;
	logic [LEN_WIDTH-1:0] length;
	logic done;
	logic engineDone;
	logic resultDone;
	logic hit;
	logic [ADDR_WIDTH-1:0] hitIndex;
	logic [SEL_WIDTH-1:0] hitSel;
	logic [LEN_WIDTH-1:0] hitLength;
	logic sumValid;
	logic [LEN_WIDTH-1:0] sumLength;

	// table ops finish in the engine, counter ops in the result stage
	assign done = engineDone | resultDone;

	FreeCmdDecode #(.ADDR_WIDTH(ADDR_WIDTH)) decode0 (
		.CLK(CLK), .RESETn(RESETn),
		.cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp),
		.cmdIndex(cmdIndex), .cmdSel(cmdSel), .cmdLength(cmdLength),
		.start(start), .op(op), .index(index), .sel(sel), .length(length),
		.done(done)
	);

	FreeScanEngine #(.ADDR_WIDTH(ADDR_WIDTH)) engine0 (
		.CLK(CLK), .RESETn(RESETn),
		.start(start), .op(op), .index(index), .sel(sel), .length(length),
		.done(engineDone), .hit(hit), .hitIndex(hitIndex),
		.hitSel(hitSel), .hitLength(hitLength),
		.sumValid(sumValid), .sumLength(sumLength)
	);

	FreeResult #(.ADDR_WIDTH(ADDR_WIDTH)) result0 (
		.CLK(CLK), .RESETn(RESETn),
		.start(start), .op(op), .length(length),
		.engineDone(engineDone), .hit(hit), .hitIndex(hitIndex),
		.hitSel(hitSel), .hitLength(hitLength),
		.sumValid(sumValid), .sumLength(sumLength),
		.done(resultDone), .found(found), .foundIndex(foundIndex),
		.foundSel(foundSel), .foundLength(foundLength),
		.freeMem(freeMem), .cachedMem(cachedMem)
	);

endmodule

// File: FreeCacheTb.sv
`timescale 1ns/1ps

module FreeCacheTb;
	import FreeCachePkg::*;

	localparam int ADDR_WIDTH = 8;
	localparam int DEPTH = 1 << ADDR_WIDTH;
	localparam int OBJ_BASE = DEPTH / 2;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int OBJ_WRITES = 40;
	localparam int LEN_FINDS = 12;
	localparam int DESC_WRITES = 20;
	localparam int MEM_OPS = 6;
	// per test: clear 3, length 2 extra, descriptor 5 extra, calc 1, counter 1, handshake 2
	localparam int NUM_CMDS = 3 + OBJ_WRITES + LEN_FINDS + 2 + DESC_WRITES + 5 + 1
		+ 1 + MEM_OPS + 2;
	localparam int WATCHDOG_NS = (NUM_CMDS * 300 + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [MEM_WIDTH-1:0] MEM_ONE = {{(MEM_WIDTH-1){1'b0}}, 1'b1};

	logic CLK = 1'b0;
	logic RESETn;
	logic cmdReq;
	logic cmdAck;
	freeOpT cmdOp;
	logic [ADDR_WIDTH-1:0] cmdIndex;
	logic [SEL_WIDTH-1:0] cmdSel;
	logic [LEN_WIDTH-1:0] cmdLength;
	logic found;
	logic [ADDR_WIDTH-1:0] foundIndex;
	logic [SEL_WIDTH-1:0] foundSel;
	logic [LEN_WIDTH-1:0] foundLength;
	logic [MEM_WIDTH-1:0] freeMem;
	logic [MEM_WIDTH-1:0] cachedMem;

	// model of the table and the two totals
	logic [SEL_WIDTH-1:0] modelSel [DEPTH];
	logic [LEN_WIDTH-1:0] modelLen [DEPTH];
	logic [MEM_WIDTH-1:0] modelFree;
	logic [MEM_WIDTH-1:0] modelCached;
	logic expFound;
	logic [ADDR_WIDTH-1:0] expIndex;
	logic [SEL_WIDTH-1:0] expSel;
	logic [LEN_WIDTH-1:0] expLength;

	// bookkeeping, one writer each
	int issued;
	int compared = 0;
	int checks = 0;
	int checkErrors = 0;
	int protocolErrors = 0;
	int stimErrors;
	int markErrors;
	logic ackPrev = 1'b0;
	logic reqPrev = 1'b0;

	FreeCache #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (
		.CLK(CLK), .RESETn(RESETn),
		.cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp),
		.cmdIndex(cmdIndex), .cmdSel(cmdSel), .cmdLength(cmdLength),
		.found(found), .foundIndex(foundIndex), .foundSel(foundSel),
		.foundLength(foundLength), .freeMem(freeMem), .cachedMem(cachedMem)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// --------------------
	// reference model
	// --------------------
	function automatic void predict(input freeOpT op, input logic [ADDR_WIDTH-1:0] idx,
			input logic [SEL_WIDTH-1:0] s, input logic [LEN_WIDTH-1:0] len);
		int lo;
		int hi;
		logic hit;
		logic [MEM_WIDTH-1:0] lenExt;
		lenExt = {{(MEM_WIDTH-LEN_WIDTH){1'b0}}, len};
		// descriptors below the middle, objects above
		lo = ((op == opFindFreeEntry) || (op == opFindUsedEntry)) ? 0 : OBJ_BASE;
		hi = ((op == opFindFreeEntry) || (op == opFindUsedEntry)) ? OBJ_BASE - 1 : DEPTH - 1;
		case (op)
			opWrite: begin
				modelSel[idx] = s;
				modelLen[idx] = len;
				expFound = 1'b0;
			end
			opClear: begin
				for (int i = 0; i < DEPTH; i++) begin
					modelSel[i] = '0;
					modelLen[i] = '0;
				end
				expFound = 1'b0;
			end
			opFindFreeObj, opFindLength, opFindFreeEntry, opFindUsedEntry: begin
				expFound = 1'b0;
				// lowest address that fits wins
				for (int i = lo; i <= hi; i++) begin
					case (op)
						opFindFreeObj, opFindFreeEntry: hit = (modelSel[i] == '0);
						opFindUsedEntry: hit = (modelSel[i] != '0);
						default: hit = (modelLen[i] >= len);
					endcase
					if (hit && !expFound) begin
						expFound = 1'b1;
						expIndex = i[ADDR_WIDTH-1:0];
						expSel = modelSel[i];
						expLength = modelLen[i];
					end
				end
			end
			opCalcCached: begin
				expFound = 1'b0;
				modelCached = '0;
				for (int i = OBJ_BASE; i < DEPTH; i++) begin
					modelCached = modelCached + {{(MEM_WIDTH-LEN_WIDTH){1'b0}}, modelLen[i]};
				end
			end
			opMemClear: modelFree = '0;
			opMemAdd: modelFree = modelFree + lenExt;
			// subtract takes one extra unit
			opMemSub: modelFree = modelFree - lenExt - MEM_ONE;
			// opMemNone, counter and found untouched
			default: begin
			end
		endcase
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic checkFound(input logic got, input logic [ADDR_WIDTH-1:0] gotIndex,
			input logic [SEL_WIDTH-1:0] gotSel, input logic [LEN_WIDTH-1:0] gotLen);
		checks++;
		if ((got !== expFound) || (expFound && ((gotIndex !== expIndex)
				|| (gotSel !== expSel) || (gotLen !== expLength)))) begin
			checkErrors++;
			$display("Error at %0d ns: found %b index %0d sel %h len %h, expected %b %0d %h %h",
				$time, got, gotIndex, gotSel, gotLen, expFound, expIndex, expSel, expLength);
		end
	endtask

	task automatic checkFreeMem(input logic [MEM_WIDTH-1:0] got);
		checks++;
		if (got !== modelFree) begin
			checkErrors++;
			$display("Error at %0d ns: freeMem %h, expected %h", $time, got, modelFree);
		end
	endtask

	task automatic checkCachedMem(input logic [MEM_WIDTH-1:0] got);
		checks++;
		if (got !== modelCached) begin
			checkErrors++;
			$display("Error at %0d ns: cachedMem %h, expected %h", $time, got, modelCached);
		end
	endtask

	// results are stable by the falling edge after cmdAck rises
	always @(negedge CLK) begin
		if (cmdAck && (compared != issued)) begin
			compared++;
			checkFound(found, foundIndex, foundSel, foundLength);
			checkFreeMem(freeMem);
			checkCachedMem(cachedMem);
		end
	end

	// handshake monitor, pre-edge values only
	always @(posedge CLK) begin
		if (cmdAck && !ackPrev && !reqPrev) begin
			protocolErrors++;
			$display("Error at %0d ns: cmdAck rose while cmdReq was low", $time);
		end
		if (!cmdAck && ackPrev && reqPrev) begin
			protocolErrors++;
			$display("Error at %0d ns: cmdAck fell while cmdReq was still high", $time);
		end
		ackPrev <= cmdAck;
		reqPrev <= cmdReq;
	end

	// --------------------
	// stimulus
	// --------------------

	// one four-phase transaction, request optionally held past the ack
	task automatic runCommand(input freeOpT op, input logic [ADDR_WIDTH-1:0] idx,
			input logic [SEL_WIDTH-1:0] s, input logic [LEN_WIDTH-1:0] len, input int hold);
		predict(op, idx, s, len);
		@(negedge CLK);
		cmdOp = op;
		cmdIndex = idx;
		cmdSel = s;
		cmdLength = len;
		issued++;
		cmdReq = 1'b1;
		do begin
			@(negedge CLK);
		end while (!cmdAck);
		repeat (hold) begin
			@(negedge CLK);
			if (!cmdAck) begin
				stimErrors++;
				$display("cmdAck went away although cmdReq was still held, at %0d ns", $time);
			end
		end
		cmdReq = 1'b0;
		do begin
			@(negedge CLK);
		end while (cmdAck);
	endtask

	task automatic finishTest(input string name);
		int total;
		total = checkErrors + protocolErrors + stimErrors;
		$display("test %s: %0d errors", name, total - markErrors);
		markErrors = total;
	endtask

	initial begin
		logic [31:0] r;
		logic [ADDR_WIDTH-1:0] idx;
		logic [SEL_WIDTH-1:0] s;
		int total;
		void'($urandom(32'h3ea4_8382));
		RESETn = 1'b0;
		cmdReq = 1'b0;
		cmdOp = opMemNone;
		cmdIndex = '0;
		cmdSel = '0;
		cmdLength = '0;
		issued = 0;
		stimErrors = 0;
		markErrors = 0;
		modelFree = '0;
		modelCached = '0;
		expFound = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		if ((cmdAck !== 1'b0) || (found !== 1'b0) || (freeMem !== '0) || (cachedMem !== '0)) begin
			stimErrors++;
			$display("Error at %0d ns: outputs not cleared by reset", $time);
		end
		RESETn = 1'b1;

		// empty table after clear
		runCommand(opClear, '0, '0, '0, 0);
		runCommand(opFindFreeObj, '0, '0, '0, 0);
		runCommand(opFindUsedEntry, '0, '0, '0, 0);
		finishTest("clear");

		// scattered objects, then length searches
		for (int i = 0; i < OBJ_WRITES; i++) begin
			r = $urandom;
			idx = {1'b1, r[ADDR_WIDTH-2:0]};
			r = $urandom;
			s = r[SEL_WIDTH-1:0];
			runCommand(opWrite, idx, s, $urandom, 0);
		end
		for (int i = 0; i < LEN_FINDS; i++) begin
			runCommand(opFindLength, '0, '0, $urandom, 0);
		end
		// largest request, usually a miss
		runCommand(opFindLength, '0, '0, '1, 0);
		runCommand(opFindFreeObj, '0, '0, '0, 0);
		finishTest("length search");

		// dense run at the bottom, then scattered, a quarter of those free
		for (int i = 0; i < DESC_WRITES; i++) begin
			r = $urandom;
			idx = (i < 8) ? i[ADDR_WIDTH-1:0] : {1'b0, r[ADDR_WIDTH-2:0]};
			r = $urandom;
			s = ((i >= 8) && (r[31:30] == 2'b00)) ? '0 : {r[SEL_WIDTH-1:1], 1'b1};
			runCommand(opWrite, idx, s, $urandom, 0);
		end
		runCommand(opFindFreeEntry, '0, '0, '0, 0);
		runCommand(opFindUsedEntry, '0, '0, '0, 0);
		// freeing entry 0 moves both answers
		runCommand(opWrite, '0, '0, '0, 0);
		runCommand(opFindFreeEntry, '0, '0, '0, 0);
		runCommand(opFindUsedEntry, '0, '0, '0, 0);
		finishTest("descriptor search");

		runCommand(opCalcCached, '0, '0, '0, 0);
		finishTest("cached total");

		runCommand(opMemClear, '0, '0, '0, 0);
		for (int i = 0; i < MEM_OPS; i++) begin
			r = $urandom;
			case (i % 3)
				0: runCommand(opMemAdd, '0, '0, r, 0);
				1: runCommand(opMemSub, '0, '0, r & 32'h3ff, 0);
				default: runCommand(opMemNone, '0, '0, r, 0);
			endcase
		end
		finishTest("free counter");

		// held request must add once, the no-op reads the counter back
		runCommand(opMemAdd, '0, '0, 32'd1000, 8);
		runCommand(opMemNone, '0, '0, '0, 0);
		finishTest("handshake");

		total = checkErrors + protocolErrors + stimErrors;
		$display("%0d commands, %0d checks, %0d errors", issued, checks, total);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// generous bound, 300 cycles per command
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a command never completed", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: FreeCache.f
FreeCachePkg.sv
FreeCacheRam.sv
FreeCmdDecode.sv
FreeScanEngine.sv
FreeResult.sv
FreeCache.sv
FreeCacheTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= FreeCacheTb
FILELIST  ?= FreeCache.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
